// File: Bender.yml
package:
  name: emesh_cdc

sources:
  - include_dirs:
      - source
    files:
      - source/emesh_pkg.sv
      - source/cdc_pkg.sv
      - source/gray_sync.sv
      - source/fifo_async.sv
      - source/fifo_cdc.sv
      - source/emesh_cdc_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/emesh_cdc_properties.sv
      - testbench/emesh_cdc_tb.sv

// File: emesh_cdc_top.f
+incdir+source
source/emesh_pkg.sv
source/cdc_pkg.sv
source/gray_sync.sv
source/fifo_async.sv
source/fifo_cdc.sv
source/emesh_cdc_top.sv
testbench/emesh_cdc_properties.sv
testbench/emesh_cdc_tb.sv

// File: source/cdc_pkg.sv
// Pointer and status types shared by the async FIFO, its synchronizers and the CDC wrapper
`default_nettype none

`include "emesh_cdc_cfg.svh"

package cdc_pkg;

   // Address bits plus one wrap bit
   // Holds either binary or gray form
   typedef logic [$clog2(`EMESH_CDC_DEPTH):0] cdc_ptr_t;

   // FIFO flags handed to the flow control wrapper
   typedef struct packed {
      logic full;
      logic empty;
   } cdc_status_t;

endpackage

`default_nettype wire

// File: source/emesh_cdc_cfg.svh
// Build-time sizing for the packet CDC, include wherever FIFO depth or sync depth is needed
`ifndef EMESH_CDC_CFG_SVH
`define EMESH_CDC_CFG_SVH

// FIFO entries per crossing
// Must be a power of two for gray pointer wrap
`define EMESH_CDC_DEPTH 16

// Synchronizer flops per pointer crossing
// Two is the usual minimum for metastability settling
`define EMESH_CDC_SYNC_STAGES 2

// Depth of 16 gives 5 bit pointers
// Extra MSB separates full from empty

// Raising sync stages adds read latency
// Full flag also reacts later to reads

// Keep both values in sync with the testbench watchdog

`endif

// File: source/emesh_cdc_top.sv
// Top level of the bidirectional packet CDC, requests toward clk_out and responses back
`timescale 1ns/100ps
`default_nettype none

module emesh_cdc_top
   import emesh_pkg::*;
(
   input  logic          clk_in,
   input  logic          clk_out,
   input  logic          nreset,
   // Requests, clk_in to clk_out
   input  logic          req_access_in,
   input  emesh_packet_t req_packet_in,
   output logic          req_wait_out,
   output logic          req_access_out,
   output emesh_packet_t req_packet_out,
   input  logic          req_wait_in,
   // Responses, clk_out to clk_in
   input  logic          resp_access_in,
   input  emesh_resp_t   resp_packet_in,
   output logic          resp_wait_out,
   output logic          resp_access_out,
   output emesh_resp_t   resp_packet_out,
   input  logic          resp_wait_in
);

   // Request crossing
   fifo_cdc #(
      .payload_t (emesh_packet_t)
   ) u_req_cdc (
      .nreset     (nreset),
      .clk_in     (clk_in),
      .access_in  (req_access_in),
      .packet_in  (req_packet_in),
      .wait_out   (req_wait_out),
      .clk_out    (clk_out),
      .access_out (req_access_out),
      .packet_out (req_packet_out),
      .wait_in    (req_wait_in)
   );

   // Response crossing, clocks swapped
   fifo_cdc #(
      .payload_t (emesh_resp_t)
   ) u_resp_cdc (
      .nreset     (nreset),
      .clk_in     (clk_out),
      .access_in  (resp_access_in),
      .packet_in  (resp_packet_in),
      .wait_out   (resp_wait_out),
      .clk_out    (clk_in),
      .access_out (resp_access_out),
      .packet_out (resp_packet_out),
      .wait_in    (resp_wait_in)
   );

endmodule

`default_nettype wire

// File: source/emesh_pkg.sv
// Packet formats carried by the request and response crossings, imported by top and wrappers
`default_nettype none

package emesh_pkg;

   // Request packet, 104 bits
   // MSB first as seen on the fabric
   typedef struct packed {
      logic        write;
      logic [1:0]  datamode;
      logic [4:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [31:0] data;
      logic [31:0] srcaddr;
   } emesh_packet_t;

   // Response packet, 40 bits
   // Tag matches the response back to its request
   typedef struct packed {
      logic [7:0]  tag;
      logic [31:0] data;
   } emesh_resp_t;

endpackage

`default_nettype wire

// File: source/fifo_async.sv
// Dual-clock FIFO with gray pointers, used by the CDC wrapper for either payload type
`timescale 1ns/100ps
`default_nettype none

`include "emesh_cdc_cfg.svh"

module fifo_async
   import cdc_pkg::*;
   import emesh_pkg::*;
#(
   parameter type payload_t = emesh_packet_t
) (
   input  logic        wr_clk,
   input  logic        rd_clk,
   input  logic        nreset,
   input  logic        wr_en,
   input  payload_t    din,
   input  logic        rd_en,
   output payload_t    dout,
   output cdc_status_t status
);

   localparam int unsigned DEPTH = `EMESH_CDC_DEPTH;
   localparam int unsigned AW    = $clog2(DEPTH);

   // Top two gray bits flip when writer is one lap ahead
   localparam cdc_ptr_t FULL_MASK = cdc_ptr_t'(2'b11) << (AW - 1);

   // Storage
   payload_t mem [DEPTH];

   // Write domain pointers
   cdc_ptr_t wr_bin;
   cdc_ptr_t wr_bin_next;
   cdc_ptr_t wr_gray;
   cdc_ptr_t rd_gray_wr;

   // Read domain pointers
   cdc_ptr_t rd_bin;
   cdc_ptr_t rd_bin_next;
   cdc_ptr_t rd_gray;
   cdc_ptr_t wr_gray_rd;

   function automatic cdc_ptr_t bin2gray(input cdc_ptr_t bin);
      return bin ^ (bin >> 1);
   endfunction

   //
   // Write side
   //
   assign wr_bin_next = wr_bin + cdc_ptr_t'(wr_en);

   always_ff @(posedge wr_clk or negedge nreset) begin
      if (!nreset) begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end else begin
         wr_bin  <= wr_bin_next;
         wr_gray <= bin2gray(wr_bin_next);
      end
   end

   // Payload array, no reset
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         mem[wr_bin[AW-1:0]] <= din;
      end
   end

   // Read pointer into write domain
   gray_sync u_rd_sync (
      .clk_out (wr_clk),
      .nreset  (nreset),
      .ptr_in  (rd_gray),
      .ptr_out (rd_gray_wr)
   );

   //
   // Read side
   //
   assign rd_bin_next = rd_bin + cdc_ptr_t'(rd_en);

   always_ff @(posedge rd_clk or negedge nreset) begin
      if (!nreset) begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end else begin
         rd_bin  <= rd_bin_next;
         rd_gray <= bin2gray(rd_bin_next);
      end
   end

   // Output register, holds between reads
   always_ff @(posedge rd_clk) begin
      if (rd_en) begin
         dout <= mem[rd_bin[AW-1:0]];
      end
   end

   // Write pointer into read domain
   gray_sync u_wr_sync (
      .clk_out (rd_clk),
      .nreset  (nreset),
      .ptr_in  (wr_gray),
      .ptr_out (wr_gray_rd)
   );

   // Full in write domain, empty in read domain
   // Both pessimistic since far pointer lags
   always_comb begin
      status.full  = (wr_gray == (rd_gray_wr ^ FULL_MASK));
      status.empty = (rd_gray == wr_gray_rd);
   end

endmodule

`default_nettype wire

// File: source/fifo_cdc.sv
// Access/wait wrapper around the async FIFO, one instance per crossing direction
`timescale 1ns/100ps
`default_nettype none

module fifo_cdc
   import cdc_pkg::*;
   import emesh_pkg::*;
#(
   parameter type payload_t = emesh_packet_t
) (
   input  logic     nreset,
   // Sending side
   input  logic     clk_in,
   input  logic     access_in,
   input  payload_t packet_in,
   output logic     wait_out,
   // Receiving side
   input  logic     clk_out,
   output logic     access_out,
   output payload_t packet_out,
   input  logic     wait_in
);

   cdc_status_t status;
   logic        wr_en;
   logic        rd_en;

   // Accept only while room left
   assign wr_en    = access_in & ~status.full;
   // Pop only when receiver is ready
   assign rd_en    = ~status.empty & ~wait_in;
   // Back-pressure is the true full flag
   assign wait_out = status.full;

   // Valid follows the read by one cycle
   // Frozen while receiver waits
   always_ff @(posedge clk_out or negedge nreset) begin
      if (!nreset) begin
         access_out <= 1'b0;
      end else if (!wait_in) begin
         access_out <= rd_en;
      end
   end

   fifo_async #(
      .payload_t (payload_t)
   ) u_fifo (
      .wr_clk (clk_in),
      .rd_clk (clk_out),
      .nreset (nreset),
      .wr_en  (wr_en),
      .din    (packet_in),
      .rd_en  (rd_en),
      .dout   (packet_out),
      .status (status)
   );

endmodule

`default_nettype wire

// File: source/gray_sync.sv
// Gray pointer synchronizer, one instance per pointer that crosses into the other clock
`timescale 1ns/100ps
`default_nettype none

`include "emesh_cdc_cfg.svh"

module gray_sync
   import cdc_pkg::*;
(
   input  logic     clk_out,
   input  logic     nreset,
   input  cdc_ptr_t ptr_in,
   output cdc_ptr_t ptr_out
);

   localparam int unsigned STAGES = `EMESH_CDC_SYNC_STAGES;

   // Flop chain clocked by destination clock
   cdc_ptr_t sync_q [STAGES];

   always_ff @(posedge clk_out or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < STAGES; i++) begin
            sync_q[i] <= '0;
         end
      end else begin
         // First stage may go metastable
         // Gray input limits it to one bit in doubt
         sync_q[0] <= ptr_in;
         for (int i = 1; i < STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   // Settled copy from last stage
   assign ptr_out = sync_q[STAGES-1];

endmodule

`default_nettype wire

// File: testbench/emesh_cdc_patterns.txt
// One hex word per line: request count, request packets, response count, response packets
// Request = {write,datamode,ctrlmode} byte, dstaddr, data, srcaddr; response = tag, data
12
8a80001000deadbeef00000010
4c800010041234567800000014
e180001008cafef00d00000018
0f8000100c0badc0de0000001c
a390000000ffffffff00000020
55900000040000000000000024
c790000008a5a5a5a500000028
319000000c5a5a5a5a0000002c
9ea000001013579bdf00000030
72a00000142468ace000000034
d8a0000018fedcba9800000038
16a000001c765432100000003c
bbb00001000123456700000040
6db000010489abcdef00000044
f0b0000108c0ffee0000000048
29b000010c800000010000004c
84c00002007fffffff00000050
5ec000020455aa33cc00000054
05
a10000cafe
b212345678
c3deadbeef
d400000001
e5fffffff0

// File: testbench/emesh_cdc_properties.sv
// Concurrent checks on the access/wait wrapper, bound into every fifo_cdc instance
`timescale 1ns/100ps
`default_nettype none

module emesh_cdc_properties
   import cdc_pkg::*;
   import emesh_pkg::*;
#(
   parameter type payload_t = emesh_packet_t
) (
   input logic     clk_in,
   input logic     clk_out,
   input logic     nreset,
   input logic     wait_out,
   input cdc_ptr_t wr_ptr,
   input logic     access_out,
   input payload_t packet_out,
   input logic     wait_in
);

   // Failed assertions in this instance
   int fail_count = 0;

   // Stalled beat keeps its payload
   hold_stable: assert property (@(posedge clk_out) disable iff (!nreset)
      access_out && wait_in |=> $stable(packet_out))
      else begin
         $error("packet_out changed while the receiver was waiting");
         fail_count++;
      end

   // Full FIFO takes no write
   // Write pointer stands still across a full edge
   no_write_when_full: assert property (@(posedge clk_in) disable iff (!nreset)
      wait_out |=> $stable(wr_ptr))
      else begin
         $error("write accepted while wait_out was high");
         fail_count++;
      end

   // Output side idle in reset
   idle_in_reset: assert property (@(posedge clk_out) !nreset |-> !access_out)
      else begin
         $error("access_out high during reset");
         fail_count++;
      end

endmodule

`default_nettype wire

// File: testbench/emesh_cdc_tb.sv
// Self-checking testbench for the packet CDC, replays the pattern file through both crossings
`timescale 1ns/100ps
`default_nettype none

`include "emesh_cdc_cfg.svh"

module emesh_cdc_tb
   import emesh_pkg::*;
();

   localparam int          DEPTH          = `EMESH_CDC_DEPTH;
   localparam int          CLK_OUT_PERIOD = 10;
   localparam real         CLK_IN_PERIOD  = 7.0;
   localparam logic [31:0] SEED           = 32'h9134f6c0;

   // Test ids, index names and error counters
   localparam int T_RESET = 0;
   localparam int T_FULL  = 1;
   localparam int T_REQ   = 2;
   localparam int T_RESP  = 3;
   localparam int T_HOLD  = 4;
   localparam int T_SIM   = 5;
   localparam int N_TESTS = 6;

   string test_names [N_TESTS] = '{"reset_state", "full_flag", "request_order",
                                   "response_order", "hold_under_wait", "simultaneous_traffic"};
   int    errs [N_TESTS];

   logic          clk_in, clk_out, nreset;
   logic          req_access_in, req_wait_out, req_access_out, req_wait_in;
   logic          resp_access_in, resp_wait_out, resp_access_out, resp_wait_in;
   emesh_packet_t req_packet_in, req_packet_out;
   emesh_resp_t   resp_packet_in, resp_packet_out;

   // Pattern storage and scoreboards
   logic [103:0]  pat_mem [64];
   emesh_packet_t req_pat [$];
   emesh_resp_t   resp_pat [$];
   emesh_packet_t req_q [$];
   emesh_resp_t   resp_q [$];
   int            n_req, n_resp, req_rx, resp_rx, rx_before, hold_seen;
   int            total_errs, failed_tests, assert_fails;
   int            drain_cycles;
   int            req_test_id = T_FULL;
   // Wait modes: 0 held high, 1 low, 2 random
   int            req_wait_mode = 0;
   int            resp_wait_mode = 1;
   longint        timeout_ns = 0;
   logic [31:0]   req_rng, resp_rng;
   emesh_packet_t req_held;
   emesh_resp_t   resp_held;
   logic          req_hold_chk = 1'b0;
   logic          resp_hold_chk = 1'b0;

   emesh_cdc_top dut (
      .clk_in          (clk_in),
      .clk_out         (clk_out),
      .nreset          (nreset),
      .req_access_in   (req_access_in),
      .req_packet_in   (req_packet_in),
      .req_wait_out    (req_wait_out),
      .req_access_out  (req_access_out),
      .req_packet_out  (req_packet_out),
      .req_wait_in     (req_wait_in),
      .resp_access_in  (resp_access_in),
      .resp_packet_in  (resp_packet_in),
      .resp_wait_out   (resp_wait_out),
      .resp_access_out (resp_access_out),
      .resp_packet_out (resp_packet_out),
      .resp_wait_in    (resp_wait_in)
   );

   bind fifo_cdc emesh_cdc_properties #(
      .payload_t (payload_t)
   ) u_props (
      .clk_in     (clk_in),
      .clk_out    (clk_out),
      .nreset     (nreset),
      .wait_out   (wait_out),
      .wr_ptr     (u_fifo.wr_bin),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input int test_id, input logic [103:0] expected,
                              input logic [103:0] actual);
      if (expected !== actual) begin
         $display("Mismatch in %s: expected %0h, actual %0h", test_names[test_id],
                  expected, actual);
         errs[test_id]++;
      end
   endtask

   task automatic report_error(input int test_id, input string what);
      $display("Error in %s: %s", test_names[test_id], what);
      errs[test_id]++;
   endtask

   task automatic report_test(input int test_id);
      $display("Test %s: %s, %0d errors", test_names[test_id],
               (errs[test_id] == 0) ? "ok" : "failed", errs[test_id]);
   endtask

   initial begin
      clk_out = 1'b0;
      forever #(CLK_OUT_PERIOD / 2) clk_out = ~clk_out;
   end

   initial begin
      clk_in = 1'b0;
      forever #(CLK_IN_PERIOD / 2.0) clk_in = ~clk_in;
   end

   // Receiver back-pressure, one stream per side
   initial begin
      req_wait_in = 1'b1;
      req_rng = SEED;
      forever begin
         @(posedge clk_out);
         req_rng = lcg_next(req_rng);
         req_wait_in <= (req_wait_mode == 2) ? req_rng[31] : (req_wait_mode == 0);
      end
   end

   initial begin
      resp_wait_in = 1'b1;
      resp_rng = lcg_next(SEED);
      forever begin
         @(posedge clk_in);
         resp_rng = lcg_next(resp_rng);
         resp_wait_in <= (resp_wait_mode == 2) ? resp_rng[31] : (resp_wait_mode == 0);
      end
   end

   // Monitors sample between edges
   // Beat moves on the next rising edge
   always @(negedge clk_out) begin
      if (req_hold_chk) begin
         check_value(T_HOLD, req_held, req_packet_out);
      end
      req_hold_chk = req_access_out && req_wait_in;
      req_held = req_packet_out;
      if (req_hold_chk) begin
         hold_seen++;
      end
      if (req_access_out && !req_wait_in) begin
         // Every beat counts, extra ones show in the totals
         req_rx++;
         if (req_q.size() == 0) begin
            report_error(req_test_id, "request beat arrived with nothing pending");
         end else begin
            check_value(req_test_id, req_q.pop_front(), req_packet_out);
         end
      end
   end

   always @(negedge clk_in) begin
      if (resp_hold_chk) begin
         check_value(T_HOLD, resp_held, resp_packet_out);
      end
      resp_hold_chk = resp_access_out && resp_wait_in;
      resp_held = resp_packet_out;
      if (resp_hold_chk) begin
         hold_seen++;
      end
      if (resp_access_out && !resp_wait_in) begin
         resp_rx++;
         if (resp_q.size() == 0) begin
            report_error(T_RESP, "response beat arrived with nothing pending");
         end else begin
            check_value(T_RESP, resp_q.pop_front(), resp_packet_out);
         end
      end
   end

   // Sender holds the beat until wait_out is low
   task automatic drive_requests();
      for (int i = 0; i < n_req; i++) begin
         @(posedge clk_in);
         req_access_in <= 1'b1;
         req_packet_in <= req_pat[i];
         @(negedge clk_in);
         while (req_wait_out) begin
            @(negedge clk_in);
         end
         req_q.push_back(req_pat[i]);
      end
      @(posedge clk_in);
      req_access_in <= 1'b0;
   endtask

   task automatic drive_responses();
      for (int i = 0; i < n_resp; i++) begin
         @(posedge clk_out);
         resp_access_in <= 1'b1;
         resp_packet_in <= resp_pat[i];
         @(negedge clk_out);
         while (resp_wait_out) begin
            @(negedge clk_out);
         end
         resp_q.push_back(resp_pat[i]);
      end
      @(posedge clk_out);
      resp_access_in <= 1'b0;
   endtask

   // Reader stalled since reset, count writes until full
   task automatic run_full_flag();
      int accepted = 0;
      @(posedge clk_in);
      req_access_in <= 1'b1;
      req_packet_in <= req_pat[0];
      @(negedge clk_in);
      while (!req_wait_out && accepted <= DEPTH) begin
         req_q.push_back(req_pat[accepted]);
         accepted++;
         @(posedge clk_in);
         req_packet_in <= req_pat[accepted];
         @(negedge clk_in);
      end
      check_value(T_FULL, DEPTH, accepted);
      @(posedge clk_in);
      req_access_in <= 1'b0;
      @(negedge clk_out);
      check_value(T_FULL, 0, req_access_out);
      // Release the reader, FIFO drains in order
      req_wait_mode = 1;
      wait (req_q.size() == 0);
      @(negedge clk_in);
      check_value(T_FULL, 0, req_wait_out);
   endtask

   initial begin
      nreset = 1'b0;
      req_access_in = 1'b0;
      req_packet_in = '0;
      resp_access_in = 1'b0;
      resp_packet_in = '0;
      $readmemh("testbench/emesh_cdc_patterns.txt", pat_mem);
      n_req = int'(pat_mem[0]);
      for (int i = 1; i <= n_req; i++) begin
         req_pat.push_back(pat_mem[i]);
      end
      n_resp = int'(pat_mem[n_req + 1]);
      for (int i = 0; i < n_resp; i++) begin
         resp_pat.push_back(pat_mem[n_req + 2 + i][39:0]);
      end
      timeout_ns = longint'(n_req + n_resp) * DEPTH * 4 * CLK_OUT_PERIOD;
      if (n_req <= DEPTH || n_resp == 0) begin
         report_error(T_RESET, "patterns file is missing or holds too few packets");
      end else begin
         repeat (8) @(posedge clk_out);
         nreset <= 1'b1;
         @(negedge clk_out);
         check_value(T_RESET, 0,
                     {req_access_out, resp_access_out, req_wait_out, resp_wait_out});
         report_test(T_RESET);
         run_full_flag();
         report_test(T_FULL);
         // Both crossings at once under random back-pressure
         @(negedge clk_out);
         req_test_id = T_REQ;
         req_wait_mode = 2;
         resp_wait_mode = 2;
         rx_before = req_rx;
         fork
            drive_requests();
            drive_responses();
         join
         // Bounded drain, leftovers stay in the scoreboards
         drain_cycles = 0;
         while ((req_q.size() != 0 || resp_q.size() != 0) && drain_cycles < 8 * DEPTH) begin
            @(posedge clk_out);
            drain_cycles++;
         end
         // Quiet window shows up any duplicated beat
         repeat (2 * DEPTH) @(posedge clk_out);
         check_value(T_REQ, n_req, req_rx - rx_before);
         report_test(T_REQ);
         check_value(T_RESP, n_resp, resp_rx);
         report_test(T_RESP);
         if (hold_seen == 0) begin
            report_error(T_HOLD, "the receiver never held a valid beat");
         end
         report_test(T_HOLD);
         check_value(T_SIM, 0, req_q.size() + resp_q.size());
         check_value(T_SIM, DEPTH + n_req + n_resp, req_rx + resp_rx);
         report_test(T_SIM);
      end
      assert_fails = dut.u_req_cdc.u_props.fail_count + dut.u_resp_cdc.u_props.fail_count;
      if (assert_fails != 0) begin
         $display("Error: %0d failures in the bound assertions", assert_fails);
      end
      total_errs = assert_fails;
      failed_tests = 0;
      for (int i = 0; i < N_TESTS; i++) begin
         total_errs += errs[i];
         failed_tests += (errs[i] != 0);
      end
      $display("Summary: %0d tests, %0d failed, %0d errors", N_TESTS, failed_tests, total_errs);
      if (total_errs == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // Watchdog scaled by pattern count
   initial begin
      wait (timeout_ns > 0);
      #(timeout_ns);
      $display("Timeout: run still busy after %0d ns, a handshake never completed", timeout_ns);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire
